//--- Makefile
TOP = sram_subsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- bench/sram_stim.txt
# op id addr len strb seed; op and len decimal, the rest hex
# op 0 write, 1 read, 2 write and read raised together; reads ignore strb and seed
0 3 00000040 0 f 11110000
1 5 00000040 0 0 00000000
0 1 00001000 15 f a0000000
1 2 00001000 15 0 00000000
0 4 00000100 3 f 22220000
0 6 00000104 1 5 55550000
0 7 0000010c 0 a 77770000
1 8 00000100 3 0 00000000
0 9 00002000 7 f 90000000
1 a 00002000 7 0 00000000
1 b 00001020 5 0 00000000
0 c 0000fff8 5 f c0000000
1 d 0000fff8 5 0 00000000
1 e 00000000 3 0 00000000
0 1 00010080 1 f 31000000
1 2 00000080 1 0 00000000
2 5 00003000 3 f d0000000
1 6 00003000 3 0 00000000
0 0 00000044 0 f 000000ee
2 4 00000044 0 c 0000ab00
1 f 00000040 1 0 00000000
1 7 00000ff8 3 0 00000000
2 9 00000ff8 1 6 00660000
1 c 00000ff0 5 0 00000000

//--- bench/sram_subsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sram_subsystem_properties (
  input wire                             clk,
  input wire                             rst,
  input wire axi_sram_pkg::slave_state_t state,
  input wire                             aw_valid,
  input wire                             ar_ready,
  input wire axi_sram_pkg::r_beat_t      r,
  input wire                             r_valid,
  input wire                             r_ready,
  input wire axi_sram_pkg::b_resp_t      b,
  input wire                             b_valid,
  input wire                             b_ready,
  input wire axi_sram_pkg::axi_strb_t    mem_we
);

  // one transaction open, so never both response channels
  r_b_exclusive: assert property (@(posedge clk) disable iff (rst) !(r_valid && b_valid))
    else $error("r_valid and b_valid high in the same cycle");

  r_stable: assert property (@(posedge clk) disable iff (rst)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("r payload changed while stalled");

  b_stable: assert property (@(posedge clk) disable iff (rst)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b payload changed while stalled");

  // byte enables only while taking write beats
  we_in_write: assert property (@(posedge clk) disable iff (rst)
    state != axi_sram_pkg::st_write |-> mem_we == '0)
    else $error("mem_we active outside st_write");

  write_first: assert property (@(posedge clk) disable iff (rst) aw_valid |-> !ar_ready)
    else $error("ar_ready high while aw_valid is pending");

endmodule

bind axi_sram_slave sram_subsystem_properties props0 (
  .clk      (clk),
  .rst      (rst),
  .state    (state),
  .aw_valid (aw_valid),
  .ar_ready (ar_ready),
  .r        (r),
  .r_valid  (r_valid),
  .r_ready  (r_ready),
  .b        (b),
  .b_valid  (b_valid),
  .b_ready  (b_ready),
  .mem_we   (mem_we)
);

`default_nettype wire

//--- bench/sram_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module sram_subsystem_tb;

  logic                    clk;
  logic                    rst;
  axi_sram_pkg::addr_req_t aw;
  logic                    aw_valid;
  logic                    aw_ready;
  axi_sram_pkg::w_beat_t   w;
  logic                    w_valid;
  logic                    w_ready;
  axi_sram_pkg::b_resp_t   b;
  logic                    b_valid;
  logic                    b_ready;
  axi_sram_pkg::addr_req_t ar;
  logic                    ar_valid;
  logic                    ar_ready;
  axi_sram_pkg::r_beat_t   r;
  logic                    r_valid;
  logic                    r_ready;

  // expected sram contents
  axi_sram_pkg::axi_data_t shadow [0:(1 << `SRAM_ADDR_BITS)-1];

  // one entry per stim line
  int op_q[$];
  int id_q[$];
  int addr_q[$];
  int len_q[$];
  int strb_q[$];
  int seed_q[$];

  logic [15:0] lfsr;
  int          budget;

  sram_subsystem dut0 (
    .clk      (clk),
    .rst      (rst),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
  );

  always #5 clk = ~clk;

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("error %s expected %h actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic v);
    lfsr = lfsr_step(lfsr);
    v = lfsr[0];
  endtask

  function automatic axi_sram_pkg::addr_req_t build_request(input int id_i, input int addr_i,
                                                            input int len_i);
    axi_sram_pkg::addr_req_t req;
    req.id   = axi_sram_pkg::axi_id_t'(id_i);
    req.addr = axi_sram_pkg::axi_addr_t'(addr_i);
    req.len  = axi_sram_pkg::axi_len_t'(len_i);
    return req;
  endfunction

  // word of a beat wraps in the 14 bit word space
  function automatic axi_sram_pkg::sram_addr_t beat_word(input axi_sram_pkg::addr_req_t req,
                                                          input int beat);
    return axi_sram_pkg::sram_addr_t'((req.addr >> 2) + axi_sram_pkg::axi_addr_t'(beat));
  endfunction

  task automatic load_stim();
    int    fd;
    int    code;
    int    n;
    int    op;
    int    id;
    int    addr;
    int    len;
    int    strb;
    int    seed;
    string line;
    fd = $fopen("bench/sram_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file bench/sram_stim.txt");
      $display("sim failed");
      $fatal(1, "stimulus file missing");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %h %h %d %h %h", op, id, addr, len, strb, seed);
          if (n == 6) begin
            op_q.push_back(op);
            id_q.push_back(id);
            addr_q.push_back(addr);
            len_q.push_back(len);
            strb_q.push_back(strb);
            seed_q.push_back(seed);
            budget += (len + 1) * 20;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_burst(input axi_sram_pkg::addr_req_t req,
                             input axi_sram_pkg::axi_strb_t strb,
                             input axi_sram_pkg::axi_data_t seed, input string name);
    axi_sram_pkg::sram_addr_t word;
    axi_sram_pkg::axi_data_t  data;
    axi_sram_pkg::b_resp_t    exp_b;
    logic                     ready_bit;
    logic                     done;
    aw <= req;
    aw_valid <= 1'b1;
    do @(negedge clk); while (!aw_ready);
    @(posedge clk);
    aw_valid <= 1'b0;
    for (int beat = 0; beat <= int'(req.len); beat++) begin
      data = seed + axi_sram_pkg::axi_data_t'(beat);
      w <= '{data: data, strb: strb, last: (beat == int'(req.len))};
      w_valid <= 1'b1;
      do @(negedge clk); while (!w_ready);
      @(posedge clk);
      word = beat_word(req, beat);
      for (int k = 0; k < `AXI_STRB_BITS; k++) begin
        if (strb[k]) begin
          shadow[word][k*8 +: 8] = data[k*8 +: 8];
        end
      end
    end
    w_valid <= 1'b0;
    exp_b = '{id: req.id, resp: `AXI_RESP_OKAY};
    done = 1'b0;
    while (!done) begin
      draw_bit(ready_bit);
      b_ready <= ready_bit;
      @(negedge clk);
      if (b_valid && b_ready) begin
        check({name, " b"}, 64'(exp_b), 64'(b));
        done = 1'b1;
      end
      @(posedge clk);
    end
    b_ready <= 1'b0;
  endtask

  task automatic read_burst(input axi_sram_pkg::addr_req_t req, input string name);
    axi_sram_pkg::r_beat_t exp_r;
    logic                  ready_bit;
    int                    beat;
    do @(negedge clk); while (!ar_ready);
    @(posedge clk);
    ar_valid <= 1'b0;
    beat = 0;
    while (beat <= int'(req.len)) begin
      draw_bit(ready_bit);
      r_ready <= ready_bit;
      @(negedge clk);
      if (r_valid && r_ready) begin
        exp_r = '{data: shadow[beat_word(req, beat)], id: req.id, resp: `AXI_RESP_OKAY,
                  last: (beat == int'(req.len))};
        check($sformatf("%s r%0d", name, beat), 64'(exp_r), 64'(r));
        beat++;
      end
      @(posedge clk);
    end
    r_ready <= 1'b0;
  endtask

  // op 0 writes and op 1 reads while op 2 raises both address channels together
  task automatic run_txn(input int t);
    axi_sram_pkg::addr_req_t req;
    string                   name;
    req = build_request(id_q[t], addr_q[t], len_q[t]);
    name = $sformatf("txn%0d", t);
    if (op_q[t] != 0) begin
      ar <= req;
      ar_valid <= 1'b1;
    end
    if (op_q[t] != 1) begin
      write_burst(req, axi_sram_pkg::axi_strb_t'(strb_q[t]),
                  axi_sram_pkg::axi_data_t'(seed_q[t]), name);
    end
    if (op_q[t] != 0) begin
      read_burst(req, name);
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("timeout after %0d cycles, a handshake never completed", cycles);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    lfsr = 16'd24;
    budget = 200;
    load_stim();
    fork
      watchdog(budget);
    join_none
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int t = 0; t < op_q.size(); t++) begin
      run_txn(t);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/axi_sram_pkg.sv
`default_nettype none
`include "sram_config.svh"

package axi_sram_pkg;

  // plain widths
  typedef logic [`AXI_ID_BITS-1:0]    axi_id_t;
  typedef logic [`AXI_ADDR_BITS-1:0]  axi_addr_t;
  typedef logic [`AXI_LEN_BITS-1:0]   axi_len_t;
  typedef logic [`AXI_DATA_BITS-1:0]  axi_data_t;
  typedef logic [`AXI_STRB_BITS-1:0]  axi_strb_t;
  typedef logic [1:0]                 axi_resp_t;
  typedef logic [`SRAM_ADDR_BITS-1:0] sram_addr_t;

  // aw and ar payload
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } addr_req_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_beat_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_resp_t;

  typedef struct packed {
    axi_data_t data;
    axi_id_t   id;
    axi_resp_t resp;
    logic      last;
  } r_beat_t;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write,
    st_resp
  } slave_state_t;

endpackage

`default_nettype wire

//--- source/axi_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module axi_sram_slave (
  input  wire                             clk,
  input  wire                             rst,
  input  wire axi_sram_pkg::addr_req_t    aw,
  input  wire                             aw_valid,
  output logic                            aw_ready,
  input  wire axi_sram_pkg::w_beat_t      w,
  input  wire                             w_valid,
  output logic                            w_ready,
  output axi_sram_pkg::b_resp_t           b,
  output logic                            b_valid,
  input  wire                             b_ready,
  input  wire axi_sram_pkg::addr_req_t    ar,
  input  wire                             ar_valid,
  output logic                            ar_ready,
  output axi_sram_pkg::r_beat_t           r,
  output logic                            r_valid,
  input  wire                             r_ready,
  output logic                            mem_en,
  output axi_sram_pkg::axi_strb_t         mem_we,
  output axi_sram_pkg::sram_addr_t        mem_addr,
  output axi_sram_pkg::axi_data_t         mem_wdata,
  input  wire axi_sram_pkg::axi_data_t    mem_rdata
);

  axi_sram_pkg::slave_state_t state;
  axi_sram_pkg::slave_state_t state_next;

  // burst context
  axi_sram_pkg::axi_id_t    id_q;
  axi_sram_pkg::axi_len_t   len_q;
  axi_sram_pkg::sram_addr_t base_q;
  axi_sram_pkg::axi_len_t   cnt;

  axi_sram_pkg::addr_req_t  req_sel;
  axi_sram_pkg::sram_addr_t beat_addr;
  axi_sram_pkg::sram_addr_t next_addr;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;
  logic r_last;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign b_hs  = b_valid && b_ready;
  assign ar_hs = ar_valid && ar_ready;
  assign r_hs  = r_valid && r_ready;

  // write wins when both address channels are valid
  assign aw_ready = (state == axi_sram_pkg::st_idle);
  assign ar_ready = (state == axi_sram_pkg::st_idle) && !aw_valid;
  assign w_ready  = (state == axi_sram_pkg::st_write);
  assign b_valid  = (state == axi_sram_pkg::st_resp);
  assign r_valid  = (state == axi_sram_pkg::st_read);

  assign r_last = (cnt == len_q);

  always_comb begin
    state_next = state;
    case (state)
      axi_sram_pkg::st_idle: begin
        if (aw_hs) begin
          state_next = axi_sram_pkg::st_write;
        end else if (ar_hs) begin
          state_next = axi_sram_pkg::st_read;
        end
      end
      axi_sram_pkg::st_read: begin
        if (r_hs && r_last) begin
          state_next = axi_sram_pkg::st_idle;
        end
      end
      axi_sram_pkg::st_write: begin
        if (w_hs && w.last) begin
          state_next = axi_sram_pkg::st_resp;
        end
      end
      axi_sram_pkg::st_resp: begin
        if (b_hs) begin
          state_next = axi_sram_pkg::st_idle;
        end
      end
      default: state_next = axi_sram_pkg::st_idle;
    endcase
  end

  // beat counter, restarts with each burst
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= axi_sram_pkg::st_idle;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (aw_hs || ar_hs || (r_hs && r_last) || (w_hs && w.last)) begin
        cnt <= '0;
      end else if (r_hs || w_hs) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  assign req_sel = aw_hs ? aw : ar;

  always_ff @(posedge clk) begin
    if (aw_hs || ar_hs) begin
      id_q   <= req_sel.id;
      len_q  <= req_sel.len;
      base_q <= req_sel.addr[`SRAM_ADDR_BITS+1:2];
    end
  end

  // wraps inside the word space by width
  assign beat_addr = base_q + axi_sram_pkg::sram_addr_t'(cnt);
  assign next_addr = beat_addr + 1'b1;

  always_comb begin
    mem_en   = 1'b0;
    mem_addr = beat_addr;
    case (state)
      axi_sram_pkg::st_idle: begin
        mem_en   = ar_hs;
        mem_addr = ar.addr[`SRAM_ADDR_BITS+1:2];
      end
      axi_sram_pkg::st_read: begin
        // fetch one beat ahead so data is ready with r_valid
        mem_en   = 1'b1;
        mem_addr = r_hs ? next_addr : beat_addr;
      end
      axi_sram_pkg::st_write: begin
        mem_en = w_hs;
      end
      default: mem_en = 1'b0;
    endcase
  end

  assign mem_we    = w.strb & {`AXI_STRB_BITS{w_hs}};
  assign mem_wdata = w.data;

  assign r = '{data: mem_rdata, id: id_q, resp: `AXI_RESP_OKAY, last: r_last};
  assign b = '{id: id_q, resp: `AXI_RESP_OKAY};

endmodule

`default_nettype wire

//--- source/sram_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "sram_config.svh"

module sram_array (
  input  wire                             clk,
  input  wire                             en,
  input  wire axi_sram_pkg::axi_strb_t    we,
  input  wire axi_sram_pkg::sram_addr_t   addr,
  input  wire axi_sram_pkg::axi_data_t    wdata,
  output axi_sram_pkg::axi_data_t         rdata
);

  localparam int depth = 1 << `SRAM_ADDR_BITS;

  axi_sram_pkg::axi_data_t mem [0:depth-1];

  // byte lane writes
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < `AXI_STRB_BITS; i++) begin
        if (we[i]) begin
          mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // read port, one cycle latency, holds when not read
  always_ff @(posedge clk) begin
    if (en && (we == '0)) begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

//--- source/sram_config.svh
`ifndef SRAM_CONFIG_SVH
`define SRAM_CONFIG_SVH

// bus side widths
`define AXI_ID_BITS     4
`define AXI_ADDR_BITS   32
`define AXI_LEN_BITS    4
`define AXI_DATA_BITS   32
`define AXI_STRB_BITS   4

// word address into the 16K word array
`define SRAM_ADDR_BITS  14

// the only response this slave gives
`define AXI_RESP_OKAY   2'b00

`endif

//--- source/sram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module sram_subsystem (
  input  wire                             clk,
  input  wire                             rst,
  input  wire axi_sram_pkg::addr_req_t    aw,
  input  wire                             aw_valid,
  output logic                            aw_ready,
  input  wire axi_sram_pkg::w_beat_t      w,
  input  wire                             w_valid,
  output logic                            w_ready,
  output axi_sram_pkg::b_resp_t           b,
  output logic                            b_valid,
  input  wire                             b_ready,
  input  wire axi_sram_pkg::addr_req_t    ar,
  input  wire                             ar_valid,
  output logic                            ar_ready,
  output axi_sram_pkg::r_beat_t           r,
  output logic                            r_valid,
  input  wire                             r_ready
);

  // memory port between slave and array
  logic                     mem_en;
  axi_sram_pkg::axi_strb_t  mem_we;
  axi_sram_pkg::sram_addr_t mem_addr;
  axi_sram_pkg::axi_data_t  mem_wdata;
  axi_sram_pkg::axi_data_t  mem_rdata;

  axi_sram_slave slave0 (
    .clk       (clk),
    .rst       (rst),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b         (b),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .ar        (ar),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .r         (r),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  sram_array array0 (
    .clk   (clk),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/axi_sram_pkg.sv
source/sram_array.sv
source/axi_sram_slave.sv
source/sram_subsystem.sv
bench/sram_subsystem_properties.sv
bench/sram_subsystem_tb.sv
